// File: common/softmc_defs.svh
`ifndef SOFTMC_DEFS_SVH
`define SOFTMC_DEFS_SVH

// Instruction memory
`define INSTR_WIDTH 32
`define IMEM_ADDR_WIDTH 8

// Read data path
`define DQ_WIDTH 64
`define RB_DEPTH 16
`define RB_CNT_WIDTH 5

// DRAM addressing
`define ROW_WIDTH 17
`define COL_WIDTH 10
`define BANK_WIDTH 2
`define BG_WIDTH 2

// RAS_n, CAS_n and WE_n share the upper address pins
`define ADR_RAS_BIT 16
`define ADR_WE_BIT 14

`endif

// File: common/softmc_pkg.sv
`default_nettype none

`include "softmc_defs.svh"

package softmc_pkg;

  // Instruction class
  typedef enum logic [2:0] {
    OP_DDR  = 3'd0,
    OP_WAIT = 3'd1,
    OP_END  = 3'd2
  } opcode_e;

  // DRAM command carried by an OP_DDR instruction
  typedef enum logic [2:0] {
    CMD_NOP = 3'd0,
    CMD_ACT = 3'd1,
    CMD_PRE = 3'd2,
    CMD_RD  = 3'd3,
    CMD_WR  = 3'd4,
    CMD_REF = 3'd5
  } ddr_cmd_e;

  // addr holds the row, the column or the WAIT cycle count
  typedef struct packed {
    opcode_e                 opcode;
    ddr_cmd_e                cmd;
    logic [`BG_WIDTH-1:0]    bg;
    logic [`BANK_WIDTH-1:0]  bank;
    logic [4:0]              spare;
    logic [`ROW_WIDTH-1:0]   addr;
  } instr_t;

  // Decoded command from the pipeline
  typedef struct packed {
    logic                    valid;
    ddr_cmd_e                cmd;
    logic [`BG_WIDTH-1:0]    bg;
    logic [`BANK_WIDTH-1:0]  bank;
    logic [`ROW_WIDTH-1:0]   addr;
  } ddr_req_t;

  // DDR4 command pins
  typedef struct packed {
    logic                    act_n;
    logic                    cs_n;
    logic [`ROW_WIDTH-1:0]   adr;
    logic [`BANK_WIDTH-1:0]  ba;
    logic [`BG_WIDTH-1:0]    bg;
  } dram_cmd_t;

endpackage

`default_nettype wire

// File: frontend/frontend.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmc_defs.svh"

module frontend
  import softmc_pkg::*;
(
  input  wire logic                        c0_ddr4_clk,
  input  wire logic                        rst,

  // Host instruction stream
  input  wire instr_t                      h2c_data,
  input  wire logic                        h2c_valid,
  input  wire logic                        h2c_last,
  output logic                             h2c_ready,

  // Fetch port
  input  wire logic                        fetch_req,
  input  wire logic [`IMEM_ADDR_WIDTH-1:0] fetch_addr,
  output instr_t                           fetch_data,
  output logic                             fetch_valid,

  // Sequence control
  input  wire logic                        seq_done,
  input  wire logic                        rb_idle,
  output logic                             run
);

  typedef enum logic [1:0] {
    ST_LOAD,
    ST_RUN,
    ST_DRAIN
  } fe_state_e;

  fe_state_e state;
  logic [`IMEM_ADDR_WIDTH-1:0] wr_ptr;
  logic [`INSTR_WIDTH-1:0] imem [2**`IMEM_ADDR_WIDTH];
  logic h2c_xfer;

  assign h2c_ready = (state == ST_LOAD);
  assign h2c_xfer  = h2c_valid && h2c_ready;
  assign run       = (state == ST_RUN);

  // Load sequence, then run until END, then wait for readback to empty
  always_ff @(posedge c0_ddr4_clk) begin
    if (rst) begin
      state  <= ST_LOAD;
      wr_ptr <= '0;
    end else begin
      case (state)
        ST_LOAD: begin
          if (h2c_xfer) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (h2c_last) begin
              state  <= ST_RUN;
              wr_ptr <= '0;
            end
          end
        end
        ST_RUN: begin
          // Skip DRAIN when nothing is left in the read path
          if (seq_done) begin
            state <= rb_idle ? ST_LOAD : ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          if (rb_idle) begin
            state <= ST_LOAD;
          end
        end
        default: state <= ST_LOAD;
      endcase
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (h2c_xfer) begin
      imem[wr_ptr] <= h2c_data;
    end
  end

  // Registered read port, data one cycle after the request
  always_ff @(posedge c0_ddr4_clk) begin
    if (fetch_req) begin
      fetch_data <= instr_t'(imem[fetch_addr]);
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= fetch_req;
    end
  end

  // The pipeline only fetches while a sequence is running
  a_fetch_in_run: assert property (@(posedge c0_ddr4_clk) disable iff (rst)
    fetch_req |-> state == ST_RUN);

endmodule

`default_nettype wire

// File: pipeline/softmc_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmc_defs.svh"

module softmc_pipeline
  import softmc_pkg::*;
(
  input  wire logic                        c0_ddr4_clk,
  input  wire logic                        rst,
  input  wire logic                        run,

  // Fetch port
  output logic                             fetch_req,
  output logic [`IMEM_ADDR_WIDTH-1:0]      fetch_addr,
  input  wire instr_t                      fetch_data,
  input  wire logic                        fetch_valid,

  // Readback flow control
  input  wire logic [`RB_CNT_WIDTH-1:0]    buffer_space,

  output ddr_req_t                         ddr_req,
  output logic                             seq_done
);

  logic [`IMEM_ADDR_WIDTH-1:0] pc;
  logic [`IMEM_ADDR_WIDTH-1:0] inflight_addr;
  logic [`ROW_WIDTH-1:0] wait_cnt;
  logic drop_next;
  logic done;
  logic stalled;

  logic exec;
  logic is_rd;
  logic [`RB_CNT_WIDTH-1:0] pend_rd;
  logic space_ok;
  logic rd_block;
  logic wait_long;
  logic end_hit;
  logic stop;

  assign fetch_addr = pc;
  assign fetch_req  = run && !done && !stalled && (wait_cnt == '0);

  // The fetch issued in the stop cycle comes back one cycle later and is dropped
  assign exec  = run && fetch_valid && !drop_next;
  assign is_rd = (fetch_data.opcode == OP_DDR) && (fetch_data.cmd == CMD_RD);

  // A read sitting in ddr_req is not yet counted by the readback engine
  assign pend_rd  = `RB_CNT_WIDTH'(ddr_req.valid && ddr_req.cmd == CMD_RD);
  assign space_ok = buffer_space > pend_rd;

  assign rd_block = exec && is_rd && !space_ok;
  // WAIT 0 and WAIT 1 fit in the slot of the WAIT itself
  assign wait_long = exec && (fetch_data.opcode == OP_WAIT) && (fetch_data.addr > 17'd1);
  assign end_hit   = exec && (fetch_data.opcode == OP_END);
  assign stop      = rd_block || wait_long || end_hit;

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst || !run) begin
      pc            <= '0;
      inflight_addr <= '0;
      wait_cnt      <= '0;
      drop_next     <= 1'b0;
      done          <= 1'b0;
      stalled       <= 1'b0;
      seq_done      <= 1'b0;
      ddr_req       <= '0;
    end else begin
      seq_done  <= end_hit;
      drop_next <= stop;

      if (fetch_req) begin
        inflight_addr <= pc;
        pc            <= pc + 1'b1;
      end

      // Rewind the program counter over the dropped fetch
      if (rd_block) begin
        pc <= inflight_addr;
      end else if (stop) begin
        pc <= inflight_addr + 1'b1;
      end

      // Fetch restarts n-2 cycles later, giving n idle slots in total
      if (wait_long) begin
        wait_cnt <= fetch_data.addr - 17'd2;
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end

      if (rd_block) begin
        stalled <= 1'b1;
      end else if (stalled && space_ok) begin
        stalled <= 1'b0;
      end

      if (end_hit) begin
        done <= 1'b1;
      end

      ddr_req <= '{valid: exec && (fetch_data.opcode == OP_DDR) && !rd_block,
                   cmd:   fetch_data.cmd,
                   bg:    fetch_data.bg,
                   bank:  fetch_data.bank,
                   addr:  fetch_data.addr};
    end
  end

endmodule

`default_nettype wire

// File: logic/ddr_cmd_adapter.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmc_defs.svh"

module ddr_cmd_adapter
  import softmc_pkg::*;
(
  input  wire logic     c0_ddr4_clk,
  input  wire logic     rst,
  input  wire ddr_req_t ddr_req,
  output dram_cmd_t     dram_cmd,
  output logic          rd_cas,
  output logic          wr_cas
);

  dram_cmd_t next_cmd;

  // DDR4 truth table, one command per cycle
  always_comb begin
    next_cmd = '{act_n: 1'b1, cs_n: 1'b1, adr: '0, ba: ddr_req.bank, bg: ddr_req.bg};
    next_cmd.adr[`ADR_RAS_BIT:`ADR_WE_BIT] = 3'b111;
    if (ddr_req.valid) begin
      case (ddr_req.cmd)
        CMD_ACT: begin
          next_cmd.cs_n  = 1'b0;
          next_cmd.act_n = 1'b0;
          next_cmd.adr   = ddr_req.addr;
        end
        CMD_PRE: begin
          next_cmd.cs_n = 1'b0;
          next_cmd.adr  = ddr_req.addr;
          next_cmd.adr[`ADR_RAS_BIT:`ADR_WE_BIT] = 3'b010;
        end
        CMD_RD: begin
          next_cmd.cs_n = 1'b0;
          next_cmd.adr[`ADR_RAS_BIT:`ADR_WE_BIT] = 3'b101;
          next_cmd.adr[`COL_WIDTH-1:0] = ddr_req.addr[`COL_WIDTH-1:0];
        end
        CMD_WR: begin
          next_cmd.cs_n = 1'b0;
          next_cmd.adr[`ADR_RAS_BIT:`ADR_WE_BIT] = 3'b100;
          next_cmd.adr[`COL_WIDTH-1:0] = ddr_req.addr[`COL_WIDTH-1:0];
        end
        CMD_REF: begin
          next_cmd.cs_n = 1'b0;
          next_cmd.adr[`ADR_RAS_BIT:`ADR_WE_BIT] = 3'b001;
        end
        // NOP leaves the device deselected
        default: ;
      endcase
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst) begin
      dram_cmd <= '{act_n: 1'b1, cs_n: 1'b1, adr: '0, ba: '0, bg: '0};
      rd_cas   <= 1'b0;
      wr_cas   <= 1'b0;
    end else begin
      dram_cmd <= next_cmd;
      rd_cas   <= ddr_req.valid && (ddr_req.cmd == CMD_RD);
      wr_cas   <= ddr_req.valid && (ddr_req.cmd == CMD_WR);
    end
  end

  a_cas_exclusive: assert property (@(posedge c0_ddr4_clk) disable iff (rst)
    !(rd_cas && wr_cas));

endmodule

`default_nettype wire

// File: logic/readback_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmc_defs.svh"

module readback_engine (
  input  wire logic                     c0_ddr4_clk,
  input  wire logic                     rst,
  input  wire logic                     rd_cas,

  // Read data from the PHY side
  input  wire logic [`DQ_WIDTH-1:0]     rd_data,
  input  wire logic                     rd_valid,

  // Host return stream
  output logic [`DQ_WIDTH-1:0]          c2h_data,
  output logic                          c2h_valid,
  input  wire logic                     c2h_ready,

  output logic [`RB_CNT_WIDTH-1:0]      buffer_space,
  output logic                          rb_idle
);

  localparam int PTR_W = `RB_CNT_WIDTH - 1;

  logic [`DQ_WIDTH-1:0] fifo_mem [`RB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [`RB_CNT_WIDTH-1:0] fifo_count;
  logic [`RB_CNT_WIDTH-1:0] outstanding;
  logic pop;

  // Head word stays put until the host takes it
  assign c2h_valid = (fifo_count != '0);
  assign c2h_data  = fifo_mem[rd_ptr];
  assign pop       = c2h_valid && c2h_ready;

  // A strobe in this cycle already claims its slot
  assign buffer_space = `RB_CNT_WIDTH'(`RB_DEPTH) - fifo_count - outstanding
                        - `RB_CNT_WIDTH'(rd_cas);
  assign rb_idle = (fifo_count == '0) && (outstanding == '0) && !rd_cas;

  always_ff @(posedge c0_ddr4_clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_count  <= '0;
      outstanding <= '0;
    end else begin
      if (rd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_count  <= fifo_count + `RB_CNT_WIDTH'(rd_valid) - `RB_CNT_WIDTH'(pop);
      outstanding <= outstanding + `RB_CNT_WIDTH'(rd_cas) - `RB_CNT_WIDTH'(rd_valid);
    end
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (rd_valid) begin
      fifo_mem[wr_ptr] <= rd_data;
    end
  end

  // Responses only come back for reads that went out
  a_rd_expected: assert property (@(posedge c0_ddr4_clk) disable iff (rst)
    rd_valid |-> outstanding != '0);

  // Holds as long as the pipeline respects buffer_space
  a_no_overflow: assert property (@(posedge c0_ddr4_clk) disable iff (rst)
    (rd_valid && !pop) |-> fifo_count < `RB_CNT_WIDTH'(`RB_DEPTH));

endmodule

`default_nettype wire

// File: logic/softmc_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmc_defs.svh"

module softmc_top
  import softmc_pkg::*;
(
  input  wire logic                  c0_ddr4_clk,
  input  wire logic                  rst,

  // Host instruction stream
  input  wire instr_t                h2c_data,
  input  wire logic                  h2c_valid,
  input  wire logic                  h2c_last,
  output logic                       h2c_ready,

  // DDR4 command side
  output dram_cmd_t                  dram_cmd,
  output logic                       rd_cas,
  output logic                       wr_cas,
  input  wire logic [`DQ_WIDTH-1:0]  rd_data,
  input  wire logic                  rd_valid,

  // Host return stream
  output logic [`DQ_WIDTH-1:0]       c2h_data,
  output logic                       c2h_valid,
  input  wire logic                  c2h_ready
);

  logic fetch_req;
  logic [`IMEM_ADDR_WIDTH-1:0] fetch_addr;
  instr_t fetch_data;
  logic fetch_valid;
  logic run;
  logic seq_done;
  logic rb_idle;
  logic [`RB_CNT_WIDTH-1:0] buffer_space;
  ddr_req_t ddr_req;

  frontend u_frontend (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst         (rst),
    .h2c_data    (h2c_data),
    .h2c_valid   (h2c_valid),
    .h2c_last    (h2c_last),
    .h2c_ready   (h2c_ready),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .seq_done    (seq_done),
    .rb_idle     (rb_idle),
    .run         (run)
  );

  softmc_pipeline u_pipeline (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .rst          (rst),
    .run          (run),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .buffer_space (buffer_space),
    .ddr_req      (ddr_req),
    .seq_done     (seq_done)
  );

  ddr_cmd_adapter u_adapter (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst         (rst),
    .ddr_req     (ddr_req),
    .dram_cmd    (dram_cmd),
    .rd_cas      (rd_cas),
    .wr_cas      (wr_cas)
  );

  readback_engine u_readback (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .rst          (rst),
    .rd_cas       (rd_cas),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .c2h_data     (c2h_data),
    .c2h_valid    (c2h_valid),
    .c2h_ready    (c2h_ready),
    .buffer_space (buffer_space),
    .rb_idle      (rb_idle)
  );

endmodule

`default_nettype wire

// File: testbench/tb_softmc.sv
`timescale 1ns/1ns
`default_nettype none

`include "softmc_defs.svh"

module tb_softmc
  import softmc_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;

  logic c0_ddr4_clk;
  logic rst;
  instr_t h2c_data;
  logic h2c_valid;
  logic h2c_last;
  logic h2c_ready;
  dram_cmd_t dram_cmd;
  logic rd_cas;
  logic wr_cas;
  logic [`DQ_WIDTH-1:0] rd_data;
  logic rd_valid;
  logic [`DQ_WIDTH-1:0] c2h_data;
  logic c2h_valid;
  logic c2h_ready;

  // Program under construction and the expectations derived from it
  instr_t prog[$];
  instr_t exp_cmd_q[$];
  logic [`DQ_WIDTH-1:0] exp_read_q[$];
  int cmd_cycle_q[$];

  // PHY responder state
  logic [`DQ_WIDTH-1:0] rsp_word_q[$];
  int rsp_due_q[$];
  int last_due = 0;

  int cycle_cnt = 0;
  int err_cnt = 0;
  int timeout_cnt = 0;
  int rd_cas_cnt = 0;
  int wr_cas_cnt = 0;
  int exp_rd_n = 0;
  int exp_wr_n = 0;
  // 0 holds c2h_ready low, 1 holds it high, 2 gives random gaps
  int ready_mode = 1;
  logic [31:0] lcg_state = 32'd13;

  softmc_top uut (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst         (rst),
    .h2c_data    (h2c_data),
    .h2c_valid   (h2c_valid),
    .h2c_last    (h2c_last),
    .h2c_ready   (h2c_ready),
    .dram_cmd    (dram_cmd),
    .rd_cas      (rd_cas),
    .wr_cas      (wr_cas),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .c2h_data    (c2h_data),
    .c2h_valid   (c2h_valid),
    .c2h_ready   (c2h_ready)
  );

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #4 c0_ddr4_clk = ~c0_ddr4_clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Data word the PHY model returns for a read
  function automatic logic [`DQ_WIDTH-1:0] read_pattern(logic [`BG_WIDTH-1:0] g,
                                                       logic [`BANK_WIDTH-1:0] b,
                                                       logic [`COL_WIDTH-1:0] col);
    return {32'hDA7A_5EED, 16'h0000, 2'b00, g, b, col};
  endfunction

  // Expected pins for a DDR instruction
  function automatic dram_cmd_t ref_encode(instr_t ins);
    dram_cmd_t c;
    c.act_n = 1'b1;
    c.cs_n  = 1'b0;
    c.adr   = '0;
    c.ba    = ins.bank;
    c.bg    = ins.bg;
    case (ins.cmd)
      CMD_ACT: begin
        c.act_n = 1'b0;
        c.adr   = ins.addr;
      end
      CMD_PRE: begin
        c.adr        = ins.addr;
        c.adr[16:14] = 3'b010;
      end
      CMD_RD: begin
        c.adr[16:14] = 3'b101;
        c.adr[9:0]   = ins.addr[9:0];
      end
      CMD_WR: begin
        c.adr[16:14] = 3'b100;
        c.adr[9:0]   = ins.addr[9:0];
      end
      CMD_REF: c.adr[16:14] = 3'b001;
      default: c.cs_n = 1'b1;
    endcase
    return c;
  endfunction

  task automatic start_program();
    prog.delete();
    cmd_cycle_q.delete();
    rd_cas_cnt   = 0;
    wr_cas_cnt   = 0;
    exp_rd_n     = 0;
    exp_wr_n     = 0;
  endtask

  task automatic add_ddr(ddr_cmd_e c, logic [1:0] g, logic [1:0] b, logic [16:0] a);
    instr_t ins;
    ins = '{opcode: OP_DDR, cmd: c, bg: g, bank: b, spare: 5'd0, addr: a};
    prog.push_back(ins);
    exp_cmd_q.push_back(ins);
    if (c == CMD_RD) begin
      exp_read_q.push_back(read_pattern(g, b, a[9:0]));
      exp_rd_n++;
    end
    if (c == CMD_WR) begin
      exp_wr_n++;
    end
  endtask

  task automatic add_wait(int n);
    instr_t ins;
    ins = '{opcode: OP_WAIT, cmd: CMD_NOP, bg: 2'd0, bank: 2'd0, spare: 5'd0,
            addr: 17'(n)};
    prog.push_back(ins);
  endtask

  task automatic add_end();
    instr_t ins;
    ins = '{opcode: OP_END, cmd: CMD_NOP, bg: 2'd0, bank: 2'd0, spare: 5'd0,
            addr: 17'd0};
    prog.push_back(ins);
  endtask

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic report_timeout(string what);
    timeout_cnt++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  // Stops the run at the next edge once any wait has given up
  always @(posedge c0_ddr4_clk) begin : timeout_watch
    if (timeout_cnt != 0) begin
      finish_run();
    end
  end

  // Called and returns a little after a rising edge
  task automatic load_program();
    int t;
    for (int i = 0; i < prog.size(); i++) begin
      h2c_data  = prog[i];
      h2c_valid = 1'b1;
      h2c_last  = (i == prog.size() - 1);
      t = 0;
      while (!h2c_ready && t < TIMEOUT_CYCLES) begin
        @(posedge c0_ddr4_clk);
        #1;
        t++;
      end
      if (!h2c_ready) begin
        report_timeout("h2c_ready during program load");
      end
      @(posedge c0_ddr4_clk);
      #1;
    end
    h2c_valid = 1'b0;
    h2c_last  = 1'b0;
  endtask

  task automatic wait_seq_done(string name);
    int t;
    t = 0;
    while (!h2c_ready && t < TIMEOUT_CYCLES) begin
      @(posedge c0_ddr4_clk);
      #1;
      t++;
    end
    if (!h2c_ready) begin
      report_timeout({"the end of program ", name});
    end
  endtask

  task automatic check_program_end(string name);
    if (exp_cmd_q.size() != 0) begin
      $display("ERR %0t: %s ended with %0d commands missing", $time, name, exp_cmd_q.size());
      err_cnt++;
      exp_cmd_q.delete();
    end
    if (exp_read_q.size() != 0) begin
      $display("ERR %0t: %s ended with %0d read words missing", $time, name,
               exp_read_q.size());
      err_cnt++;
      exp_read_q.delete();
    end
    if (rd_cas_cnt != exp_rd_n || wr_cas_cnt != exp_wr_n) begin
      $display("ERR %0t: %s gave %0d rd_cas and %0d wr_cas, expected %0d and %0d", $time,
               name, rd_cas_cnt, wr_cas_cnt, exp_rd_n, exp_wr_n);
      err_cnt++;
    end
  endtask

  task automatic run_program(string name);
    load_program();
    wait_seq_done(name);
    check_program_end(name);
  endtask

  // PHY read responder, answers in order after a random delay
  initial begin : phy_responder
    rd_valid = 1'b0;
    rd_data  = '0;
    forever begin
      @(posedge c0_ddr4_clk);
      cycle_cnt++;
      #1;
      if (rsp_word_q.size() > 0 && cycle_cnt >= rsp_due_q[0]) begin
        rd_valid = 1'b1;
        rd_data  = rsp_word_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        rd_valid = 1'b0;
        rd_data  = '0;
      end
    end
  end

  always @(negedge c0_ddr4_clk) begin : phy_capture
    int due;
    if (!rst && rd_cas) begin
      due = cycle_cnt + 1 + int'((lcg_next() >> 16) % 8);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_word_q.push_back(read_pattern(dram_cmd.bg, dram_cmd.ba, dram_cmd.adr[9:0]));
      rsp_due_q.push_back(due);
    end
  end

  initial begin : ready_driver
    logic [31:0] rnd;
    c2h_ready = 1'b0;
    forever begin
      @(posedge c0_ddr4_clk);
      #1;
      if (ready_mode == 0) begin
        c2h_ready = 1'b0;
      end else if (ready_mode == 1) begin
        c2h_ready = 1'b1;
      end else begin
        rnd = lcg_next();
        c2h_ready = (rnd[17:16] != 2'b00);
      end
    end
  end

  // Command pins against the program, in order
  always @(negedge c0_ddr4_clk) begin : cmd_monitor
    instr_t ins;
    dram_cmd_t exp_cmd;
    if (!rst) begin
      if (rd_cas) begin
        rd_cas_cnt++;
      end
      if (wr_cas) begin
        wr_cas_cnt++;
      end
      if (!dram_cmd.cs_n) begin
        cmd_cycle_q.push_back(cycle_cnt);
        if (exp_cmd_q.size() == 0) begin
          $display("ERR %0t: unexpected command %h", $time, dram_cmd);
          err_cnt++;
        end else begin
          ins = exp_cmd_q.pop_front();
          exp_cmd = ref_encode(ins);
          if (dram_cmd !== exp_cmd) begin
            $display("ERR %0t: command pins %h, expected %h", $time, dram_cmd, exp_cmd);
            err_cnt++;
          end
          if (rd_cas !== (ins.cmd == CMD_RD) || wr_cas !== (ins.cmd == CMD_WR)) begin
            $display("ERR %0t: CAS strobes rd %b wr %b for command %0d", $time, rd_cas,
                     wr_cas, ins.cmd);
            err_cnt++;
          end
        end
      end else if (rd_cas || wr_cas) begin
        $display("ERR %0t: CAS strobe with cs_n high", $time);
        err_cnt++;
      end
    end
  end

  always @(negedge c0_ddr4_clk) begin : c2h_checker
    logic [`DQ_WIDTH-1:0] exp_word;
    if (!rst && c2h_valid && c2h_ready) begin
      if (exp_read_q.size() == 0) begin
        $display("ERR %0t: unexpected read word %h", $time, c2h_data);
        err_cnt++;
      end else begin
        exp_word = exp_read_q.pop_front();
        if (c2h_data !== exp_word) begin
          $display("ERR %0t: read word %h, expected %h", $time, c2h_data, exp_word);
          err_cnt++;
        end
      end
    end
  end

  initial begin : main
    logic [31:0] rnd;
    int n;
    int t;
    rst       = 1'b1;
    h2c_data  = '0;
    h2c_valid = 1'b0;
    h2c_last  = 1'b0;
    repeat (5) @(posedge c0_ddr4_clk);
    #1;
    rst = 1'b0;

    // Idle outputs after reset
    repeat (3) @(posedge c0_ddr4_clk);
    #1;
    if (h2c_ready !== 1'b1 || dram_cmd.cs_n !== 1'b1 || dram_cmd.act_n !== 1'b1 ||
        rd_cas !== 1'b0 || wr_cas !== 1'b0 || c2h_valid !== 1'b0) begin
      $display("ERR %0t: outputs not idle after reset", $time);
      err_cnt++;
    end

    start_program();
    add_ddr(CMD_ACT, 2'd1, 2'd2, 17'h1_2345);
    add_ddr(CMD_WR, 2'd1, 2'd2, 17'h0_03A5);
    add_ddr(CMD_RD, 2'd1, 2'd2, 17'h1_C0F0);
    add_ddr(CMD_PRE, 2'd1, 2'd2, 17'h0_0400);
    add_ddr(CMD_REF, 2'd0, 2'd0, 17'h0_0000);
    add_end();
    run_program("encoding");

    for (int k = 0; k < 2; k++) begin
      n = (k == 0) ? 3 : 20;
      start_program();
      add_ddr(CMD_ACT, 2'd0, 2'd1, 17'(n));
      add_wait(n);
      add_ddr(CMD_PRE, 2'd0, 2'd1, 17'h0_0000);
      add_end();
      run_program("wait spacing");
      if (cmd_cycle_q.size() != 2) begin
        $display("ERR %0t: WAIT %0d program gave %0d commands", $time, n, cmd_cycle_q.size());
        err_cnt++;
      end else if (cmd_cycle_q[1] - cmd_cycle_q[0] < n + 1) begin
        $display("ERR %0t: WAIT %0d spacing is %0d cycles", $time, n,
                 cmd_cycle_q[1] - cmd_cycle_q[0]);
        err_cnt++;
      end
    end

    // Random reads with random host gaps
    start_program();
    add_ddr(CMD_ACT, 2'd2, 2'd3, 17'h0_0777);
    for (int i = 0; i < 12; i++) begin
      rnd = lcg_next();
      add_ddr(CMD_RD, rnd[31:30], rnd[29:28], {7'd0, rnd[25:16]});
    end
    add_ddr(CMD_PRE, 2'd2, 2'd3, 17'h0_0000);
    add_end();
    ready_mode = 2;
    run_program("read return");
    ready_mode = 1;

    // Host holds off until the readback FIFO fills
    start_program();
    add_ddr(CMD_ACT, 2'd3, 2'd0, 17'h0_1234);
    for (int i = 0; i < 24; i++) begin
      add_ddr(CMD_RD, 2'd3, 2'd0, 17'(i * 8));
    end
    add_ddr(CMD_PRE, 2'd3, 2'd0, 17'h0_0000);
    add_end();
    ready_mode = 0;
    load_program();
    t = 0;
    while (rd_cas_cnt < `RB_DEPTH && t < TIMEOUT_CYCLES) begin
      @(posedge c0_ddr4_clk);
      #1;
      t++;
    end
    if (rd_cas_cnt < `RB_DEPTH) begin
      report_timeout("the readback buffer to fill");
    end
    repeat (40) @(posedge c0_ddr4_clk);
    #1;
    if (rd_cas_cnt > `RB_DEPTH) begin
      $display("ERR %0t: %0d reads issued with a full buffer", $time, rd_cas_cnt);
      err_cnt++;
    end
    ready_mode = 1;
    wait_seq_done("buffer stall");
    check_program_end("buffer stall");

    // A different program after the drain
    start_program();
    add_ddr(CMD_REF, 2'd2, 2'd1, 17'h0_0000);
    add_ddr(CMD_ACT, 2'd3, 2'd3, 17'h1_FFFF);
    add_ddr(CMD_WR, 2'd3, 2'd3, 17'h0_0155);
    add_ddr(CMD_WR, 2'd3, 2'd3, 17'h0_02AA);
    add_ddr(CMD_RD, 2'd3, 2'd3, 17'h0_0155);
    add_ddr(CMD_PRE, 2'd3, 2'd3, 17'h1_0400);
    add_end();
    run_program("reload");

    finish_run();
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/softmc_pkg.sv
frontend/frontend.sv
pipeline/softmc_pipeline.sv
logic/ddr_cmd_adapter.sv
logic/readback_engine.sv
logic/softmc_top.sv
testbench/tb_softmc.sv

// File: Bender.yml
package:
  name: softmc

sources:
  - include_dirs:
      - common
    files:
      - common/softmc_pkg.sv
      - frontend/frontend.sv
      - pipeline/softmc_pipeline.sv
      - logic/ddr_cmd_adapter.sv
      - logic/readback_engine.sv
      - logic/softmc_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_softmc.sv
